/* design/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Architectural data word width
`define EXU_XLEN 32

// Reorder buffer tag width, 8 entries
`define EXU_TAG_W 3

// One shift-add iteration per multiplier bit
`define EXU_MUL_STEPS 32

`endif

/* design/exu_pkg.sv */
`include "exu_macros.svh"

package exu_pkg;

    // Vector types with a meaning
    typedef logic [`EXU_XLEN-1:0]   word_t;
    typedef logic [2*`EXU_XLEN-1:0] dword_t;
    typedef logic [4:0]             reg_idx_t;
    typedef logic [`EXU_TAG_W-1:0]  rob_tag_t;

    // ALU op, funct3 in the low bits, bit 3 picks sub/sra
    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SRA  = 4'b1101;

    // Branch compare, same as branch funct3
    typedef logic [2:0] cmp_op_t;
    localparam cmp_op_t CMP_BEQ  = 3'b000;
    localparam cmp_op_t CMP_BNE  = 3'b001;
    localparam cmp_op_t CMP_BLT  = 3'b100;
    localparam cmp_op_t CMP_BGE  = 3'b101;
    localparam cmp_op_t CMP_BLTU = 3'b110;
    localparam cmp_op_t CMP_BGEU = 3'b111;

    // Multiply kind, low two bits of the M-extension funct3
    typedef logic [1:0] mul_op_t;
    localparam mul_op_t MUL_MUL    = 2'b00;
    localparam mul_op_t MUL_MULH   = 2'b01;
    localparam mul_op_t MUL_MULHSU = 2'b10;
    localparam mul_op_t MUL_MULHU  = 2'b11;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    // One packet from the reservation station
    typedef struct packed {
        logic     start;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    pc;
        word_t    imm;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        logic     op1_is_pc;
        logic     op2_is_imm;
        logic     is_branch;
        logic     is_mul;
        alu_op_t  alu_op;
        cmp_op_t  cmp_op;
        mul_op_t  mul_op;
    } issue_pkt_t;

    typedef struct packed {
        word_t rs1_value;
        word_t rs2_value;
    } reg_resp_t;

    typedef struct packed {
        word_t alu_a;
        word_t alu_b;
        word_t cmp_a;
        word_t cmp_b;
    } operands_t;

    // One common data bus slot
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
        logic     br_taken;
    } cdb_t;

endpackage

/* design/operand_select.sv */
module operand_select
    import exu_pkg::*;
(
    input  issue_pkt_t issue,
    input  reg_resp_t  regs,
    output operands_t  ops
);

    word_t rs1_val;
    word_t rs2_val;

    // x0 reads as zero whatever the register file returned
    assign rs1_val = (issue.rs1_idx == '0) ? '0 : regs.rs1_value;
    assign rs2_val = (issue.rs2_idx == '0) ? '0 : regs.rs2_value;

    always_comb begin
        // First operand, PC for auipc, jumps and branch targets
        if (issue.op1_is_pc) begin
            ops.alu_a = issue.pc;
        end else begin
            ops.alu_a = rs1_val;
        end

        // Second operand, immediate or rs2
        if (issue.op2_is_imm) begin
            ops.alu_b = issue.imm;
        end else begin
            ops.alu_b = rs2_val;
        end

        // Comparator always sees registers
        // so a branch can compare while the ALU adds pc and imm
        ops.cmp_a = rs1_val;
        ops.cmp_b = rs2_val;
    end

endmodule

/* design/int_alu.sv */
module int_alu
    import exu_pkg::*;
(
    input  alu_op_t   alu_op,
    input  cmp_op_t   cmp_op,
    input  operands_t ops,
    output word_t     result,
    output logic      br_taken
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       equal;

    // Shifts only look at five bits
    assign shamt = ops.alu_b[4:0];

    // ALU op
    always_comb begin
        result = '0;
        case (alu_op)
            ALU_ADD:  result = ops.alu_a + ops.alu_b;
            ALU_SUB:  result = ops.alu_a - ops.alu_b;
            ALU_SLL:  result = ops.alu_a << shamt;
            ALU_SLT:  result[0] = $signed(ops.alu_a) < $signed(ops.alu_b);
            ALU_SLTU: result[0] = ops.alu_a < ops.alu_b;
            ALU_XOR:  result = ops.alu_a ^ ops.alu_b;
            ALU_SRL:  result = ops.alu_a >> shamt;
            ALU_SRA:  result = word_t'($signed(ops.alu_a) >>> shamt);
            ALU_OR:   result = ops.alu_a | ops.alu_b;
            ALU_AND:  result = ops.alu_a & ops.alu_b;
            default:  result = '0;
        endcase
    end

    // Comparator works on raw register values
    assign equal       = (ops.cmp_a == ops.cmp_b);
    assign lt_signed   = ($signed(ops.cmp_a) < $signed(ops.cmp_b));
    assign lt_unsigned = (ops.cmp_a < ops.cmp_b);

    always_comb begin
        case (cmp_op)
            CMP_BEQ:  br_taken = equal;
            CMP_BNE:  br_taken = !equal;
            CMP_BLT:  br_taken = lt_signed;
            CMP_BGE:  br_taken = !lt_signed;
            CMP_BLTU: br_taken = lt_unsigned;
            CMP_BGEU: br_taken = !lt_unsigned;
            // funct3 010 and 011 are not branches
            default:  br_taken = 1'b0;
        endcase
    end

endmodule

/* design/shift_add_mul.sv */
`include "exu_macros.svh"

module shift_add_mul
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  mul_op_t mul_op,
    input  word_t   a,
    input  word_t   b,
    output dword_t  product,
    output logic    done
);

    localparam int CNT_W = $clog2(`EXU_MUL_STEPS);

    mul_state_e       state;
    logic [CNT_W-1:0] step;
    logic             a_neg;
    logic             b_neg;
    word_t            a_mag;
    word_t            b_mag;
    logic             negate;
    dword_t           acc;
    dword_t           mcand;
    word_t            mplier;

    // mulh signs both, mulhsu only a, mul and mulhu neither
    assign a_neg = ((mul_op == MUL_MULH) || (mul_op == MUL_MULHSU)) && a[`EXU_XLEN-1];
    assign b_neg = (mul_op == MUL_MULH) && b[`EXU_XLEN-1];

    // Magnitudes, 0x80000000 stays correct as unsigned
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    // Control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MUL_IDLE;
            step  <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    // Start while busy never reaches here
                    if (start) begin
                        state <= MUL_RUN;
                        step  <= '0;
                    end
                end
                MUL_RUN: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(`EXU_MUL_STEPS - 1)) begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: state <= MUL_IDLE;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    // Datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if ((state == MUL_IDLE) && start) begin
            acc    <= '0;
            mcand  <= {{`EXU_XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            negate <= a_neg ^ b_neg;
        end else if (state == MUL_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Sign fix applied on the way out in the done cycle
    assign product = negate ? -acc : acc;
    assign done    = (state == MUL_DONE);

endmodule

/* design/fu_cluster.sv */
`include "exu_macros.svh"

module fu_cluster
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  issue_pkt_t issue,
    input  reg_resp_t  regs,
    output logic       mul_available,
    output cdb_t       cdb_alu,
    output cdb_t       cdb_mul
);

    operands_t ops;
    word_t     alu_result;
    logic      alu_br_taken;
    logic      mul_start;
    dword_t    mul_product;
    logic      mul_done;
    rob_tag_t  mul_tag_q;
    reg_idx_t  mul_rd_q;
    mul_op_t   mul_op_q;

    operand_select u_operand_select (
        .issue (issue),
        .regs  (regs),
        .ops   (ops)
    );

    int_alu u_int_alu (
        .alu_op   (issue.alu_op),
        .cmp_op   (issue.cmp_op),
        .ops      (ops),
        .result   (alu_result),
        .br_taken (alu_br_taken)
    );

    // Multiply only accepted while the unit is free
    assign mul_start = issue.start && issue.is_mul && mul_available;

    shift_add_mul u_shift_add_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .mul_op  (issue.mul_op),
        .a       (ops.alu_a),
        .b       (ops.alu_b),
        .product (mul_product),
        .done    (mul_done)
    );

    // Busy from the cycle after acceptance until the result is out
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_available <= 1'b1;
        end else if (mul_start) begin
            mul_available <= 1'b0;
        end else if (mul_done) begin
            mul_available <= 1'b1;
        end
    end

    // Destination info of the multiply in flight
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_tag_q <= issue.tag;
            mul_rd_q  <= issue.rd;
            mul_op_q  <= issue.mul_op;
        end
    end

    // ALU slot answers in the issue cycle
    always_comb begin
        cdb_alu.valid    = issue.start && !issue.is_mul;
        cdb_alu.tag      = issue.tag;
        cdb_alu.rd       = issue.rd;
        cdb_alu.value    = alu_result;
        cdb_alu.br_taken = issue.is_branch && alu_br_taken;
    end

    // Multiply slot, mul takes the low word and the rest the high word
    always_comb begin
        cdb_mul.valid    = mul_done;
        cdb_mul.tag      = mul_tag_q;
        cdb_mul.rd       = mul_rd_q;
        cdb_mul.value    = (mul_op_q == MUL_MUL) ? mul_product[`EXU_XLEN-1:0]
                                                 : mul_product[2*`EXU_XLEN-1:`EXU_XLEN];
        cdb_mul.br_taken = 1'b0;
    end

endmodule

/* dv/exu_clock_gen.sv */
module exu_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    // Free running clock, low first
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held over the first rising edges, dropped on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* dv/fu_cluster_tb.sv */
`include "exu_macros.svh"

module fu_cluster_tb
    import exu_pkg::*;
();

    localparam int PERIOD     = 20;
    localparam int RESET_CYC  = 10;
    localparam int NUM_ISSUES = 600;
    localparam int DRAIN_MAX  = 40;
    localparam int MUL_LAT    = `EXU_MUL_STEPS + 1;

    // One multiply the model expects on the bus
    typedef struct packed {
        int       due;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
    } mul_expect_t;

    logic       clk;
    logic       rst;
    issue_pkt_t issue;
    reg_resp_t  regs;
    logic       mul_available;
    cdb_t       cdb_alu;
    cdb_t       cdb_mul;

    mul_expect_t pending [$];
    logic        model_avail;
    int          cycle;
    int          mul_count;
    int          drain;

    exu_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYC)) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    fu_cluster dut (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .regs          (regs),
        .mul_available (mul_available),
        .cdb_alu       (cdb_alu),
        .cdb_mul       (cdb_mul)
    );

    task automatic report_failure(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        assert (got == exp) else
            report_failure($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h at cycle %0d",
                                     name, got, exp, cycle));
    endtask

    // Edge values mixed in with plain random words
    function automatic word_t pick_word();
        case ($urandom % 8)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    // Index zero about one time in eight
    function automatic reg_idx_t pick_index();
        logic [31:0] r;
        r = $urandom;
        if (r[2:0] == 3'd0) begin
            return '0;
        end
        return r[8:4];
    endfunction

    function automatic word_t alu_reference(alu_op_t op, word_t a, word_t b);
        logic [4:0] sh;
        logic       lt;
        sh = b[4:0];
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return {31'b0, lt};
            ALU_SLTU: return {31'b0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            // Logical shift with the vacated bits filled by the sign
            ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_outcome(cmp_op_t op, word_t a, word_t b);
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            CMP_BEQ:  return a == b;
            CMP_BNE:  return a != b;
            CMP_BLT:  return lt;
            CMP_BGE:  return !lt;
            CMP_BLTU: return a < b;
            CMP_BGEU: return !(a < b);
            default:  return 1'b0;
        endcase
    endfunction

    // Extend each operand per its signedness, the low 64 bits are then exact
    function automatic word_t product_word(mul_op_t op, word_t a, word_t b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        ax = {32'b0, a};
        bx = {32'b0, b};
        if ((op == MUL_MULH) || (op == MUL_MULHSU)) begin
            ax = {{32{a[31]}}, a};
        end
        if (op == MUL_MULH) begin
            bx = {{32{b[31]}}, b};
        end
        p = ax * bx;
        return (op == MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    // 15% idle, 20% multiply, the rest ALU or branch
    task automatic make_packet();
        int          roll;
        logic [31:0] r;
        logic [31:0] sel;
        roll = $urandom % 100;
        r    = $urandom;
        issue.start      = (roll >= 15);
        issue.is_mul     = (roll < 15) ? r[14] : (roll < 35);
        issue.tag        = r[2:0];
        issue.rd         = r[7:3];
        issue.mul_op     = r[9:8];
        issue.op1_is_pc  = r[10];
        issue.op2_is_imm = r[11];
        issue.is_branch  = (r[13:12] == 2'b00);
        issue.pc         = $urandom & 32'hffff_fffc;
        issue.imm        = pick_word();
        issue.rs1_idx    = pick_index();
        issue.rs2_idx    = pick_index();
        sel = $urandom % 10;
        issue.alu_op = (sel == 8) ? ALU_SUB : (sel == 9) ? ALU_SRA : sel[3:0];
        sel = $urandom % 6;
        issue.cmp_op = (sel < 2) ? sel[2:0] : sel[2:0] + 3'd2;
        // Multiplies read registers
        if (issue.start && issue.is_mul) begin
            issue.op1_is_pc  = 1'b0;
            issue.op2_is_imm = 1'b0;
            issue.is_branch  = 1'b0;
            // Accepted kinds rotate so all four get through
            if (model_avail) begin
                issue.mul_op = mul_op_t'(mul_count[1:0]);
            end
        end
        regs.rs1_value = pick_word();
        regs.rs2_value = pick_word();
    endtask

    // Compare both slots against the model, then step the model
    task automatic check_cycle();
        word_t       a;
        word_t       b;
        word_t       ca;
        word_t       cb;
        logic        exp_alu_valid;
        logic        accept;
        mul_expect_t head;
        ca = (issue.rs1_idx == '0) ? '0 : regs.rs1_value;
        cb = (issue.rs2_idx == '0) ? '0 : regs.rs2_value;
        a  = issue.op1_is_pc ? issue.pc : ca;
        b  = issue.op2_is_imm ? issue.imm : cb;
        exp_alu_valid = issue.start && !issue.is_mul;
        check_word("cdb_alu.valid", word_t'(cdb_alu.valid), word_t'(exp_alu_valid));
        if (exp_alu_valid) begin
            check_word("cdb_alu.tag", word_t'(cdb_alu.tag), word_t'(issue.tag));
            check_word("cdb_alu.rd", word_t'(cdb_alu.rd), word_t'(issue.rd));
            check_word("cdb_alu.value", cdb_alu.value, alu_reference(issue.alu_op, a, b));
            if (issue.is_branch) begin
                check_word("cdb_alu.br_taken", word_t'(cdb_alu.br_taken),
                           word_t'(branch_outcome(issue.cmp_op, ca, cb)));
            end
        end
        check_word("mul_available", word_t'(mul_available), word_t'(model_avail));
        // Acceptance follows the availability seen in this cycle
        accept = issue.start && issue.is_mul && model_avail;
        if ((pending.size() > 0) && (pending[0].due == cycle)) begin
            head = pending.pop_front();
            check_word("cdb_mul.valid", word_t'(cdb_mul.valid), 32'd1);
            check_word("cdb_mul.tag", word_t'(cdb_mul.tag), word_t'(head.tag));
            check_word("cdb_mul.rd", word_t'(cdb_mul.rd), word_t'(head.rd));
            check_word("cdb_mul.value", cdb_mul.value, head.value);
            // Free again from the next cycle
            model_avail = 1'b1;
        end else begin
            check_word("cdb_mul.valid", word_t'(cdb_mul.valid), 32'd0);
        end
        if (accept) begin
            head.due   = cycle + MUL_LAT;
            head.tag   = issue.tag;
            head.rd    = issue.rd;
            head.value = product_word(issue.mul_op, a, b);
            pending.push_back(head);
            model_avail = 1'b0;
            mul_count++;
        end
        cycle++;
    endtask

    initial begin
        void'($urandom(32'h339b9d4d));
        issue       = '0;
        regs        = '0;
        model_avail = 1'b1;
        cycle       = 0;
        mul_count   = 0;
        drain       = 0;
        // Idle inputs in the reset release cycle
        @(negedge rst);
        #(PERIOD / 4);
        check_cycle();
        repeat (NUM_ISSUES) begin
            @(negedge clk);
            make_packet();
            #(PERIOD / 4);
            check_cycle();
        end
        // Idle until the last multiply is out, plus one cycle for availability
        while (((pending.size() != 0) || !model_avail) && (drain < DRAIN_MAX)) begin
            @(negedge clk);
            issue = '0;
            #(PERIOD / 4);
            check_cycle();
            drain++;
        end
        @(negedge clk);
        issue = '0;
        #(PERIOD / 4);
        check_cycle();
        if ((pending.size() != 0) || !model_avail) begin
            report_failure("a multiply result never appeared on the bus");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // Bound on the whole run
    initial begin
        #((NUM_ISSUES + DRAIN_MAX + RESET_CYC) * PERIOD);
        report_failure("watchdog expired before the run finished");
    end

endmodule

/* vlog.f */
+incdir+design
design/exu_pkg.sv
design/operand_select.sv
design/int_alu.sv
design/shift_add_mul.sv
design/fu_cluster.sv
dv/exu_clock_gen.sv
dv/fu_cluster_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fu_cluster_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/exu_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
